/* dv/tb_ooo_core.sv */
module tb_ooo_core
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    // expected retirement entry
    // value holds store data or branch target
    typedef struct packed {
        rob_op_t   kind;
        rv32i_reg  rd;
        rv32i_word value;
        rv32i_word addr;
        tag_t      tag;
    } exp_t;

    logic       clk;
    logic       rst;
    logic       issue_valid;
    issue_t     issue_in;
    logic       issue_ready;
    logic       mem_resp;
    commit_t    commit;
    store_req_t store_req;
    logic       new_store;
    logic       flush;
    logic       br_mispredict;
    rv32i_word  pc_correct;
    rv32i_word  br_pc_mispredict;

    exp_t       exp_q [$];
    exp_t       exp_head;
    logic       exp_any;
    logic       started;
    logic       hold_mem;
    logic       store_open;
    logic [2:0] resp_delay;
    rv32i_word  next_pc;
    tag_t       next_tag;
    int         errors;

    ooo_core_top i_dut (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .issue_in         (issue_in),
        .issue_ready      (issue_ready),
        .mem_resp         (mem_resp),
        .commit           (commit),
        .store_req        (store_req),
        .new_store        (new_store),
        .flush            (flush),
        .br_mispredict    (br_mispredict),
        .pc_correct       (pc_correct),
        .br_pc_mispredict (br_pc_mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_now(string msg);
        errors++;
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic rv32i_word ref_alu(alu_op_t f, rv32i_word a, rv32i_word b);
        case (f)
            3'd1: return a - b;
            3'd2: return a & b;
            3'd3: return a | b;
            3'd4: return a ^ b;
            3'd5: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return a + b;
        endcase
    endfunction

    function automatic logic ref_taken(alu_op_t f, rv32i_word a, rv32i_word b);
        if (f == 3'd1) begin
            return a != b;
        end else if (f == 3'd2) begin
            return $signed(a) < $signed(b);
        end
        return a == b;
    endfunction

    // data cache model with a random response delay unless held off
    always @(posedge clk) begin
        if (rst) begin
            mem_resp <= 1'b0;
            resp_delay <= '0;
        end else if (mem_resp) begin
            mem_resp <= 1'b0;
            resp_delay <= 3'($urandom_range(0, 4));
        end else if (store_req.write && !hold_mem) begin
            if (resp_delay == 3'd0) begin
                mem_resp <= 1'b1;
            end else begin
                resp_delay <= resp_delay - 3'd1;
            end
        end
    end

    // a store request was already waiting in the previous cycle
    always @(posedge clk) begin
        store_open <= !rst && store_req.write && !mem_resp;
    end

    // retire events pop the reference queue
    always @(posedge clk) begin
        if (!rst && (commit.valid || flush || (store_req.write && mem_resp))) begin
            if (exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
        end
        exp_any <= exp_q.size() > 0;
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // one op per call followed by an idle cycle
    task automatic issue_op(issue_t op, exp_t e, bit track);
        int t;
        t = 0;
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) fail_now("issue_ready stayed low too long");
        end
        op.pc = next_pc;
        if (op.op == OP_BR) begin
            e.addr = next_pc;
            e.value = ref_taken(op.alu_op, op.a, op.b) ? next_pc + op.imm : next_pc + 32'd4;
        end
        next_pc = next_pc + 32'd4;
        e.tag = next_tag;
        next_tag = next_tag + 1'b1;
        issue_valid <= 1'b1;
        issue_in <= op;
        started <= 1'b1;
        @(posedge clk);
        issue_valid <= 1'b0;
        if (track) exp_q.push_back(e);
    endtask

    task automatic random_op(int kind, bit track);
        issue_t op;
        exp_t   e;
        op = '0;
        e = '0;
        op.op = rob_op_t'(kind);
        op.rd = rv32i_reg'($urandom);
        op.a = $urandom;
        op.b = $urandom;
        op.imm = $urandom_range(0, 255) << 2;
        e.kind = op.op;
        e.rd = op.rd;
        if (kind == OP_REG) begin
            op.alu_op = alu_op_t'($urandom_range(0, 5));
            e.value = ref_alu(op.alu_op, op.a, op.b);
        end else begin
            e.value = op.b;
            e.addr = op.a + op.imm;
        end
        issue_op(op, e, track);
    endtask

    task automatic branch_op(bit mispredict);
        issue_t op;
        exp_t   e;
        op = '0;
        e = '0;
        op.op = OP_BR;
        op.alu_op = alu_op_t'($urandom_range(0, 2));
        op.a = $urandom;
        // equal operands now and then
        op.b = ($urandom_range(0, 1) == 0) ? op.a : $urandom;
        // a mispredict takes the longest latency
        if (mispredict) op.b[1:0] = 2'b11;
        op.imm = $urandom_range(1, 64) << 2;
        op.pred_taken = ref_taken(op.alu_op, op.a, op.b) ^ mispredict;
        e.kind = OP_BR;
        issue_op(op, e, mispredict);
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_q.size() != 0 || i_dut.i_rob.count != 0) begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) fail_now("reorder buffer did not drain");
        end
    endtask

    task automatic wait_ready(logic level);
        int t;
        t = 0;
        while (issue_ready !== level) begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) fail_now("issue_ready did not reach the expected level");
        end
    endtask

    task automatic wait_flush();
        int t;
        t = 0;
        while (!flush) begin
            @(posedge clk);
            t++;
            if (t > WAIT_LIMIT) fail_now("mispredicted branch never flushed");
        end
        // tags start again from 0 after a flush
        next_tag = '0;
        @(posedge clk);
    endtask

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !started |-> !commit.valid && !store_req.write && !new_store && !flush)
        else fail_now("output active before any op completed");
    a_ready_late: assert property (@(posedge clk) $fell(rst) |-> !issue_ready)
        else fail_now("issue_ready high in the first cycle after reset");
    a_commit_kind: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> exp_any && exp_head.kind == OP_REG)
        else fail_now("commit when no register op was next in order");
    a_commit_rd: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.rd == exp_head.rd)
        else fail_now($sformatf("Mismatch commit.rd got %h exp %h",
            $sampled(commit.rd), $sampled(exp_head.rd)));
    a_commit_value: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.value == exp_head.value)
        else fail_now($sformatf("Mismatch commit.value got %h exp %h",
            $sampled(commit.value), $sampled(exp_head.value)));
    a_commit_tag: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.tag == exp_head.tag)
        else fail_now($sformatf("Mismatch commit.tag got %h exp %h",
            $sampled(commit.tag), $sampled(exp_head.tag)));
    a_store_kind: assert property (@(posedge clk) disable iff (rst)
        store_req.write |-> exp_any && exp_head.kind == OP_ST && !commit.valid)
        else fail_now("store request when no store was next in order");
    a_store_addr: assert property (@(posedge clk) disable iff (rst)
        store_req.write |-> store_req.addr == exp_head.addr)
        else fail_now($sformatf("Mismatch store_req.addr got %h exp %h",
            $sampled(store_req.addr), $sampled(exp_head.addr)));
    a_store_data: assert property (@(posedge clk) disable iff (rst)
        store_req.write |-> store_req.data == exp_head.value)
        else fail_now($sformatf("Mismatch store_req.data got %h exp %h",
            $sampled(store_req.data), $sampled(exp_head.value)));
    a_store_hold: assert property (@(posedge clk) disable iff (rst)
        store_req.write && !mem_resp |=> store_req.write && !new_store &&
        $stable(store_req.addr) && $stable(store_req.data))
        else fail_now("store request changed before the cache responded");
    a_new_store: assert property (@(posedge clk) disable iff (rst)
        new_store == (store_req.write && !store_open))
        else fail_now($sformatf("Mismatch new_store got %h exp %h",
            $sampled(new_store), $sampled(store_req.write && !store_open)));
    a_flush_kind: assert property (@(posedge clk) disable iff (rst)
        flush |-> exp_any && exp_head.kind == OP_BR && br_mispredict)
        else fail_now("flush when no mispredicted branch was next in order");
    a_flush_pc: assert property (@(posedge clk) disable iff (rst)
        flush |-> pc_correct == exp_head.value)
        else fail_now($sformatf("Mismatch pc_correct got %h exp %h",
            $sampled(pc_correct), $sampled(exp_head.value)));
    a_flush_br_pc: assert property (@(posedge clk) disable iff (rst)
        flush |-> br_pc_mispredict == exp_head.addr)
        else fail_now($sformatf("Mismatch br_pc_mispredict got %h exp %h",
            $sampled(br_pc_mispredict), $sampled(exp_head.addr)));
    a_mispredict_alone: assert property (@(posedge clk) disable iff (rst)
        br_mispredict |-> flush)
        else fail_now("br_mispredict without flush");

    // watchdog for the whole run
    initial begin
        repeat (20000) @(posedge clk);
        fail_now("simulation ran out of time");
    end

    initial begin
        void'($urandom(32'h1d5e_7980));
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_in = '0;
        mem_resp = 1'b0;
        started = 1'b0;
        hold_mem = 1'b0;
        next_pc = 32'h0000_1000;
        next_tag = '0;
        errors = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (40) random_op(OP_REG, 1'b1);
        repeat (30) random_op(($urandom_range(0, 2) == 0) ? OP_ST : OP_REG, 1'b1);
        repeat (12) begin
            branch_op(1'b0);
            random_op(OP_REG, 1'b1);
        end
        // stores held back fill the buffer
        drain();
        hold_mem <= 1'b1;
        random_op(OP_ST, 1'b1);
        repeat (7) random_op(($urandom_range(0, 1) == 0) ? OP_ST : OP_REG, 1'b1);
        wait_ready(1'b0);
        hold_mem <= 1'b0;
        wait_ready(1'b1);
        repeat (4) begin
            drain();
            branch_op(1'b1);
            random_op(OP_REG, 1'b0);
            random_op(OP_ST, 1'b0);
            wait_flush();
            random_op(OP_REG, 1'b1);
        end
        drain();
        repeat (5) @(posedge clk);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_ooo_core

/* hw/dispatch_unit.sv */
module dispatch_unit
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      issue_valid,
    input  issue_t    issue_in,
    input  tag_t      rob_tail,
    input  logic      rob_free,
    input  logic [NUM_LANES-1:0] lane_busy,
    output logic      issue_ready,
    output logic      alloc,
    output issue_t    lane_issue [NUM_LANES]
);

    lane_idx_t sel;
    logic      any_idle;
    // goes high one edge after reset is released
    logic      ready_en;

    // lowest numbered idle lane wins
    always_comb begin
        any_idle = 1'b0;
        sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (!lane_busy[i]) begin
                any_idle = 1'b1;
                sel = lane_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en <= 1'b0;
        end else begin
            ready_en <= 1'b1;
        end
    end

    // no issue into a cycle that is about to flush
    assign issue_ready = ready_en && rob_free && any_idle && !flush;
    assign alloc = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_issue[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < NUM_LANES; i++) begin
                lane_issue[i].valid <= 1'b0;
            end
            if (alloc) begin
                lane_issue[sel] <= issue_in;
                // the decoder's tag field is replaced by the rob tail
                lane_issue[sel].tag <= rob_tail;
                lane_issue[sel].valid <= 1'b1;
            end
        end
    end

    // the decoder has to respect issue_ready, there is no stall path
    a_issue_when_ready: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> issue_ready
    ) else $error("issue_valid asserted while issue_ready is low");

endmodule : dispatch_unit

/* hw/exec_lane.sv */
module exec_lane
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    input  issue_t op,
    output logic   busy,
    output cdb_t   result
);

    typedef enum logic {
        LANE_IDLE,
        LANE_BUSY
    } lane_state_e;

    lane_state_e state;
    logic [1:0]  cnt;
    issue_t      cur;
    logic        done;
    logic        taken;
    rv32i_word   alu_val;

    function automatic rv32i_word alu_calc(alu_op_t f, rv32i_word a, rv32i_word b);
        case (f)
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLT: return {31'b0, $signed(a) < $signed(b)};
            default: return a + b;
        endcase
    endfunction

    function automatic logic cmp_calc(alu_op_t f, rv32i_word a, rv32i_word b);
        case (f)
            CMP_NE:  return a != b;
            CMP_LT:  return $signed(a) < $signed(b);
            default: return a == b;
        endcase
    endfunction

    // latency is 1 + b[1:0], counted down from the capture edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= LANE_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (op.valid) begin
                        state <= LANE_BUSY;
                        cnt <= op.b[1:0];
                    end
                end
                LANE_BUSY: begin
                    if (cnt == 2'd0) begin
                        state <= LANE_IDLE;
                    end else begin
                        cnt <= cnt - 2'd1;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LANE_IDLE && op.valid) begin
            cur <= op;
        end
    end

    assign done = (state == LANE_BUSY) && (cnt == 2'd0);
    // free again in the result cycle, so a new op can land right behind it
    assign busy = op.valid || ((state == LANE_BUSY) && !done);

    assign alu_val = alu_calc(cur.alu_op, cur.a, cur.b);
    assign taken = cmp_calc(cur.alu_op, cur.a, cur.b);

    always_comb begin
        result.valid = done;
        result.tag = cur.tag;
        result.value = alu_val;
        result.addr = '0;
        result.mispredict = 1'b0;
        case (cur.op)
            OP_ST: begin
                result.value = cur.b;
                result.addr = cur.a + cur.imm;
            end
            OP_BR: begin
                // value is the resolved next pc, addr the branch pc
                result.value = taken ? cur.pc + cur.imm : cur.pc + PC_STEP;
                result.addr = cur.pc;
                result.mispredict = taken != cur.pred_taken;
            end
            default: ;
        endcase
    end

    a_no_op_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        op.valid |-> state == LANE_IDLE
    ) else $error("lane received an op while still busy");

endmodule : exec_lane

/* hw/ooo_core_top.sv */
module ooo_core_top
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       issue_valid,
    input  issue_t     issue_in,
    output logic       issue_ready,
    input  logic       mem_resp,
    output commit_t    commit,
    output store_req_t store_req,
    output logic       new_store,
    output logic       flush,
    output logic       br_mispredict,
    output rv32i_word  pc_correct,
    output rv32i_word  br_pc_mispredict
);

    issue_t lane_issue [NUM_LANES];
    cdb_t   cdb [NUM_LANES];
    logic [NUM_LANES-1:0] lane_busy;
    tag_t   rob_tail;
    logic   rob_free;
    logic   alloc;

    dispatch_unit i_dispatch (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_in    (issue_in),
        .rob_tail    (rob_tail),
        .rob_free    (rob_free),
        .lane_busy   (lane_busy),
        .issue_ready (issue_ready),
        .alloc       (alloc),
        .lane_issue  (lane_issue)
    );

    // identical lanes, each with its own cdb slot
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane i_lane (
            .clk    (clk),
            .rst    (rst),
            .flush  (flush),
            .op     (lane_issue[g]),
            .busy   (lane_busy[g]),
            .result (cdb[g])
        );
    end

    reorder_buffer i_rob (
        .clk              (clk),
        .rst              (rst),
        .alloc            (alloc),
        .issue_in         (issue_in),
        .cdb              (cdb),
        .mem_resp         (mem_resp),
        .rob_tail         (rob_tail),
        .rob_free         (rob_free),
        .commit           (commit),
        .store_req        (store_req),
        .new_store        (new_store),
        .flush            (flush),
        .br_mispredict    (br_mispredict),
        .pc_correct       (pc_correct),
        .br_pc_mispredict (br_pc_mispredict)
    );

endmodule : ooo_core_top

/* hw/ooo_types_pkg.sv */
package ooo_types_pkg;

    import rv32i_types_pkg::*;

    // machine sizes
    localparam int ROB_DEPTH = 8;
    localparam int NUM_LANES = 4;
    localparam int TAG_W     = $clog2(ROB_DEPTH);
    localparam int LANE_W    = $clog2(NUM_LANES);

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [LANE_W-1:0] lane_idx_t;
    // one extra bit so a full buffer can be told from an empty one
    typedef logic [TAG_W:0]    rob_cnt_t;

    // operation class kept in each reorder buffer entry
    typedef logic [1:0] rob_op_t;
    localparam rob_op_t OP_REG = 2'd0;
    localparam rob_op_t OP_ST  = 2'd1;
    localparam rob_op_t OP_BR  = 2'd2;

    // decoded op with operands, dispatch to lane
    typedef struct packed {
        logic      valid;
        rob_op_t   op;
        alu_op_t   alu_op;
        rv32i_reg  rd;
        rv32i_word a;
        rv32i_word b;
        rv32i_word imm;
        rv32i_word pc;
        logic      pred_taken;
        tag_t      tag;
    } issue_t;

    // result broadcast, one per lane
    typedef struct packed {
        logic      valid;
        tag_t      tag;
        rv32i_word value;
        rv32i_word addr;
        logic      mispredict;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        rv32i_reg  rd;
        rv32i_word value;
        tag_t      tag;
    } commit_t;

    typedef struct packed {
        logic      write;
        rv32i_word addr;
        rv32i_word data;
    } store_req_t;

endpackage : ooo_types_pkg

/* hw/reorder_buffer.sv */
module reorder_buffer
    import rv32i_types_pkg::*;
    import ooo_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       alloc,
    input  issue_t     issue_in,
    input  cdb_t       cdb [NUM_LANES],
    input  logic       mem_resp,
    output tag_t       rob_tail,
    output logic       rob_free,
    output commit_t    commit,
    output store_req_t store_req,
    output logic       new_store,
    output logic       flush,
    output logic       br_mispredict,
    output rv32i_word  pc_correct,
    output rv32i_word  br_pc_mispredict
);

    typedef enum logic {
        STORE_IDLE,
        STORE_WAIT
    } store_state_e;

    // per entry control state
    logic      rob_busy    [ROB_DEPTH];
    logic      rob_ready   [ROB_DEPTH];
    // per entry payload
    rob_op_t   rob_class   [ROB_DEPTH];
    rv32i_reg  rob_rd      [ROB_DEPTH];
    // store data or branch target
    rv32i_word rob_value   [ROB_DEPTH];
    // store address or branch pc
    rv32i_word rob_addr    [ROB_DEPTH];
    logic      rob_mispred [ROB_DEPTH];

    tag_t     head;
    tag_t     tail;
    rob_cnt_t count;

    store_state_e st_state;
    store_state_e st_next;
    logic         store_done;

    logic    head_ready;
    rob_op_t head_class;
    logic    retire;

    assign rob_tail = tail;
    assign rob_free = count != rob_cnt_t'(ROB_DEPTH);

    assign head_ready = rob_busy[head] && rob_ready[head];
    assign head_class = rob_class[head];

    // store handshake with the data cache
    always_comb begin
        st_next = st_state;
        new_store = 1'b0;
        store_done = 1'b0;
        case (st_state)
            STORE_IDLE: begin
                if (head_ready && head_class == OP_ST) begin
                    new_store = 1'b1;
                    st_next = STORE_WAIT;
                end
            end
            STORE_WAIT: begin
                if (mem_resp) begin
                    store_done = 1'b1;
                    st_next = STORE_IDLE;
                end
            end
            default: st_next = STORE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            st_state <= STORE_IDLE;
        end else begin
            st_state <= st_next;
        end
    end

    // request stays up through the response cycle
    always_comb begin
        store_req.write = new_store || (st_state == STORE_WAIT);
        store_req.addr = '0;
        store_req.data = '0;
        if (store_req.write) begin
            store_req.addr = rob_addr[head];
            store_req.data = rob_value[head];
        end
    end

    always_comb begin
        commit.valid = head_ready && (head_class == OP_REG);
        commit.rd = rob_rd[head];
        commit.value = rob_value[head];
        commit.tag = head;
    end

    // mispredicted branch at the head throws away everything behind it
    always_comb begin
        flush = head_ready && (head_class == OP_BR) && rob_mispred[head];
        br_mispredict = flush;
        pc_correct = '0;
        br_pc_mispredict = '0;
        if (flush) begin
            pc_correct = rob_value[head];
            br_pc_mispredict = rob_addr[head];
        end
    end

    // a correct branch leaves without any visible commit
    assign retire = head_ready && ((head_class == OP_REG) ||
                                   (head_class == OP_BR && !rob_mispred[head]) ||
                                   store_done);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_busy[i] <= 1'b0;
                rob_ready[i] <= 1'b0;
            end
        end else begin
            if (retire) begin
                rob_busy[head] <= 1'b0;
                rob_ready[head] <= 1'b0;
                head <= head + 1'b1;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (cdb[i].valid) begin
                    rob_ready[cdb[i].tag] <= 1'b1;
                end
            end
            if (alloc) begin
                rob_busy[tail] <= 1'b1;
                rob_ready[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            count <= count + rob_cnt_t'(alloc) - rob_cnt_t'(retire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            rob_class[tail] <= issue_in.op;
            rob_rd[tail] <= issue_in.rd;
            rob_addr[tail] <= issue_in.pc;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (cdb[i].valid) begin
                rob_value[cdb[i].tag] <= cdb[i].value;
                rob_addr[cdb[i].tag] <= cdb[i].addr;
                rob_mispred[cdb[i].tag] <= cdb[i].mispredict;
            end
        end
    end

    // results only come back for ops that are still in flight
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_cdb_chk
        a_cdb_busy: assert property (
            @(posedge clk) disable iff (rst)
            cdb[g].valid |-> rob_busy[cdb[g].tag]
        ) else $error("cdb result for an entry that is not busy");
    end

    a_alloc_not_full: assert property (
        @(posedge clk) disable iff (rst)
        alloc |-> count < rob_cnt_t'(ROB_DEPTH)
    ) else $error("allocation into a full reorder buffer");

endmodule : reorder_buffer

/* hw/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    // data and address word
    typedef logic [31:0] rv32i_word;

    // architectural register index
    typedef logic [4:0] rv32i_reg;

    // shared op code field for alu and compare
    typedef logic [2:0] alu_op_t;

    // register operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_SLT = 3'd5;

    // branch compares, carried in the same field
    localparam alu_op_t CMP_EQ = 3'd0;
    localparam alu_op_t CMP_NE = 3'd1;
    localparam alu_op_t CMP_LT = 3'd2;

    // fall-through step of a non-taken branch
    localparam rv32i_word PC_STEP = 32'd4;

endpackage : rv32i_types_pkg

/* tb.f */
hw/rv32i_types_pkg.sv
hw/ooo_types_pkg.sv
hw/dispatch_unit.sv
hw/exec_lane.sv
hw/reorder_buffer.sv
hw/ooo_core_top.sv
dv/tb_ooo_core.sv
